/* hdl/bridge_settings.svh */
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// host window address width, the two top bits are dropped by the host port
`define BRIDGE_HOST_AW 30

// core address and data word widths
`define BRIDGE_AW 32
`define BRIDGE_DW 32

// core DRAM starts here and is folded back to zero before the host base is added
`define BRIDGE_CORE_DRAM_BASE 32'h8000_0000

// accesses at or above 120 MiB into DRAM are counted as out of range
`define BRIDGE_MEM_LIMIT (120 * 1024 * 1024)

// profiler regions, indexed by core address bits 29..23
`define BRIDGE_REGIONS 128

// register indices, one word each
`define CSR_RUN   3'd0
`define CSR_ALLOC 3'd1
`define CSR_BASE  3'd2
`define CSR_PROF0 3'd3
`define CSR_PROF1 3'd4
`define CSR_PROF2 3'd5
`define CSR_PROF3 3'd6
`define CSR_OOR   3'd7

`endif

/* hdl/addr_map_pkg.sv */
`default_nettype none

`include "bridge_settings.svh"

package addr_map_pkg;

   // address as seen on the host window
   typedef logic [`BRIDGE_HOST_AW-1:0] host_addr_t;

   // address in the core's physical space
   typedef logic [`BRIDGE_AW-1:0] core_addr_t;

   // one profiler region
   typedef logic [$clog2(`BRIDGE_REGIONS)-1:0] region_t;

   // one control or status register
   typedef logic [2:0] csr_idx_t;

   // core address split into profiler fields, the region sits on bits 29..23
   typedef struct packed {
      logic [1:0]                                         upper;
      region_t                                            region;
      logic [`BRIDGE_AW-3-$clog2(`BRIDGE_REGIONS):0]      offset;
   } core_fields_t;

   // the same core word read either as a plain address or as its fields
   typedef union packed {
      core_addr_t   raw;
      core_fields_t fields;
   } core_addr_u;

endpackage

`default_nettype wire

/* hdl/link_pkg.sv */
`default_nettype none

`include "bridge_settings.svh"

package link_pkg;

   // one data word on any channel
   typedef logic [`BRIDGE_DW-1:0] word_t;

   // request from the host into the core window
   typedef struct packed {
      addr_map_pkg::host_addr_t addr;
      logic                     we;
      word_t                    data;
   } host_req_t;

   // request carrying a full core address, used on both sides of the DRAM remap
   typedef struct packed {
      addr_map_pkg::core_addr_t addr;
      logic                     we;
      word_t                    data;
   } core_req_t;

   // register access from the host
   typedef struct packed {
      addr_map_pkg::csr_idx_t idx;
      logic                   we;
      word_t                  data;
   } csr_req_t;

   // read data, valid while ack is high
   typedef struct packed {
      word_t data;
   } rsp_t;

endpackage

`default_nettype wire

/* hdl/bridge_csr.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module bridge_csr
(
   input  logic                          aclk_i,
   input  logic                          reset_i,
   input  logic                          csr_req_i,
   input  link_pkg::csr_req_t            csr_req_data_i,
   input  logic [`BRIDGE_REGIONS-1:0]    prof_map_i,
   input  link_pkg::word_t               oor_count_i,
   output logic                          csr_ack_o,
   output link_pkg::rsp_t                csr_rsp_o,
   output addr_map_pkg::core_addr_t      dram_base_o,
   output logic                          core_reset_o
);

   logic                      ack_r;
   logic                      run_r;
   logic                      alloc_r;
   addr_map_pkg::core_addr_t  base_r;
   link_pkg::rsp_t            rsp_r;
   link_pkg::word_t           rd_word;
   logic                      access;

   // a request is served once, on the edge where req is high and ack still low
   assign access = csr_req_i & ~ack_r;

   always_comb
   begin
      case (csr_req_data_i.idx)
         `CSR_RUN:   rd_word = {{(`BRIDGE_DW-1){1'b0}}, run_r};
         `CSR_ALLOC: rd_word = {{(`BRIDGE_DW-1){1'b0}}, alloc_r};
         `CSR_BASE:  rd_word = base_r;
         `CSR_PROF0: rd_word = prof_map_i[0*`BRIDGE_DW +: `BRIDGE_DW];
         `CSR_PROF1: rd_word = prof_map_i[1*`BRIDGE_DW +: `BRIDGE_DW];
         `CSR_PROF2: rd_word = prof_map_i[2*`BRIDGE_DW +: `BRIDGE_DW];
         `CSR_PROF3: rd_word = prof_map_i[3*`BRIDGE_DW +: `BRIDGE_DW];
         `CSR_OOR:   rd_word = oor_count_i;
         default:    rd_word = '0;
      endcase
   end

   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         ack_r   <= 1'b0;
         run_r   <= 1'b0;
         alloc_r <= 1'b0;
         base_r  <= '0;
      end
      else
      begin
         // ack mirrors req one cycle later in both directions
         ack_r <= csr_req_i;
         if (access && csr_req_data_i.we)
         begin
            // profiler words and the counter are read only
            case (csr_req_data_i.idx)
               `CSR_RUN:   run_r   <= csr_req_data_i.data[0];
               `CSR_ALLOC: alloc_r <= csr_req_data_i.data[0];
               `CSR_BASE:  base_r  <= csr_req_data_i.data;
               default:    ;
            endcase
         end
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (access)
         rsp_r.data <= rd_word;
   end

   assign csr_ack_o   = ack_r;
   assign csr_rsp_o   = rsp_r;
   assign dram_base_o = base_r;

   // the core stays in reset until the host sets the run bit
   assign core_reset_o = reset_i | ~run_r;

   // ack only ever rises to answer a request that is still being held
   a_ack_needs_req: assert property (@(posedge aclk_i) disable iff (reset_i)
      $rose(csr_ack_o) |-> csr_req_i);

endmodule

`default_nettype wire

/* hdl/host_addr_xlate.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module host_addr_xlate
(
   input  logic                  aclk_i,
   input  logic                  reset_i,
   input  logic                  host_req_i,
   input  link_pkg::host_req_t   host_req_data_i,
   input  logic                  core_ack_i,
   input  link_pkg::rsp_t        core_rsp_i,
   output logic                  host_ack_o,
   output link_pkg::rsp_t        host_rsp_o,
   output logic                  core_req_o,
   output link_pkg::core_req_t   core_req_data_o
);

   logic                      core_req_r;
   logic                      host_ack_r;
   link_pkg::core_req_t       core_data_r;
   link_pkg::rsp_t            rsp_r;
   addr_map_pkg::core_addr_t  xlate_addr;
   logic                      start;

   // host bit 29 selects between core DRAM and the core's local space,
   // inverted so host 0x0000_0000 lands on core 0x8000_0000
   assign xlate_addr = {~host_req_data_i.addr[`BRIDGE_HOST_AW-1], 3'b000,
                        host_req_data_i.addr[27:0]};

   // take a new host request only when both sides are fully idle
   assign start = host_req_i & ~host_ack_r & ~core_req_r & ~core_ack_i;

   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         core_req_r <= 1'b0;
         host_ack_r <= 1'b0;
      end
      else
      begin
         host_ack_r <= core_ack_i;
         // the core side is released only after the host has dropped its req,
         // so host ack can never fall while host req is still high
         if (start)
            core_req_r <= 1'b1;
         else if (core_ack_i && !host_req_i)
            core_req_r <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (start)
      begin
         core_data_r.addr <= xlate_addr;
         core_data_r.we   <= host_req_data_i.we;
         core_data_r.data <= host_req_data_i.data;
      end
      if (core_ack_i)
         rsp_r <= core_rsp_i;
   end

   assign core_req_o      = core_req_r;
   assign core_req_data_o = core_data_r;
   assign host_ack_o      = host_ack_r;
   assign host_rsp_o      = rsp_r;

   // the core raises its ack only while our request is pending
   a_no_ack_without_req: assert property (@(posedge aclk_i) disable iff (reset_i)
      $rose(core_ack_i) |-> core_req_o);

endmodule

`default_nettype wire

/* hdl/dram_remap.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module dram_remap
(
   input  logic                      aclk_i,
   input  logic                      reset_i,
   input  logic                      core_mem_req_i,
   input  link_pkg::core_req_t       core_mem_data_i,
   input  addr_map_pkg::core_addr_t  dram_base_i,
   input  logic                      mem_ack_i,
   input  link_pkg::rsp_t            mem_rsp_i,
   output logic                      core_mem_ack_o,
   output link_pkg::rsp_t            core_mem_rsp_o,
   output logic                      mem_req_o,
   output link_pkg::core_req_t       mem_req_data_o,
   output logic                      prof_v_o,
   output addr_map_pkg::region_t     prof_region_o,
   output logic                      oor_o
);

   addr_map_pkg::core_addr_u  core_addr;
   addr_map_pkg::core_addr_t  dram_offset;
   logic                      mem_req_r;
   logic                      core_ack_r;
   logic                      prof_v_r;
   link_pkg::core_req_t       mem_data_r;
   link_pkg::rsp_t            rsp_r;
   addr_map_pkg::region_t     region_r;
   logic                      oor_r;
   logic                      start;

   assign core_addr.raw = core_mem_data_i.addr;

   // folding out the core DRAM base gives the offset into host DRAM
   assign dram_offset = core_addr.raw ^ `BRIDGE_CORE_DRAM_BASE;

   assign start = core_mem_req_i & ~core_ack_r & ~mem_req_r & ~mem_ack_i;

   always_ff @(posedge aclk_i)
   begin
      if (reset_i)
      begin
         mem_req_r  <= 1'b0;
         core_ack_r <= 1'b0;
         prof_v_r   <= 1'b0;
      end
      else
      begin
         core_ack_r <= mem_ack_i;
         // event pulse lines up with the first cycle of mem req
         prof_v_r   <= start;
         if (start)
            mem_req_r <= 1'b1;
         else if (mem_ack_i && !core_mem_req_i)
            mem_req_r <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (start)
      begin
         mem_data_r.addr <= dram_offset + dram_base_i;
         mem_data_r.we   <= core_mem_data_i.we;
         mem_data_r.data <= core_mem_data_i.data;
         region_r        <= core_addr.fields.region;
         oor_r           <= (dram_offset >= `BRIDGE_MEM_LIMIT);
      end
      if (mem_ack_i)
         rsp_r <= mem_rsp_i;
   end

   assign mem_req_o      = mem_req_r;
   assign mem_req_data_o = mem_data_r;
   assign core_mem_ack_o = core_ack_r;
   assign core_mem_rsp_o = rsp_r;
   assign prof_v_o       = prof_v_r;
   assign prof_region_o  = region_r;
   assign oor_o          = oor_r;

   // the core holds its request fixed until the ack answers it
   a_req_stable: assert property (@(posedge aclk_i) disable iff (reset_i)
      (core_mem_req_i && !core_mem_ack_o) |=> $stable(core_mem_data_i));

endmodule

`default_nettype wire

/* hdl/mem_profiler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module mem_profiler
(
   input  logic                        aclk_i,
   input  logic                        core_reset_i,
   input  logic                        prof_v_i,
   input  addr_map_pkg::region_t       prof_region_i,
   input  logic                        oor_i,
   output logic [`BRIDGE_REGIONS-1:0]  prof_map_o,
   output link_pkg::word_t             oor_count_o
);

   logic [`BRIDGE_REGIONS-1:0]  map_r;
   link_pkg::word_t             count_r;

   // both are cleared with the core, so each program run starts from an empty map
   always_ff @(posedge aclk_i)
   begin
      if (core_reset_i)
      begin
         map_r   <= '0;
         count_r <= '0;
      end
      else if (prof_v_i)
      begin
         map_r[prof_region_i] <= 1'b1;
         // oor is only meaningful alongside the event pulse
         if (oor_i)
            count_r <= count_r + link_pkg::word_t'(1);
      end
   end

   assign prof_map_o  = map_r;
   assign oor_count_o = count_r;

endmodule

`default_nettype wire

/* hdl/zynq_bridge_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module zynq_bridge_top
(
   input  logic                  aclk_i,
   input  logic                  reset_i,

   input  logic                  csr_req_i,
   input  link_pkg::csr_req_t    csr_req_data_i,
   output logic                  csr_ack_o,
   output link_pkg::rsp_t        csr_rsp_o,

   input  logic                  host_req_i,
   input  link_pkg::host_req_t   host_req_data_i,
   output logic                  host_ack_o,
   output link_pkg::rsp_t        host_rsp_o,
   output logic                  core_req_o,
   output link_pkg::core_req_t   core_req_data_o,
   input  logic                  core_ack_i,
   input  link_pkg::rsp_t        core_rsp_i,

   input  logic                  core_mem_req_i,
   input  link_pkg::core_req_t   core_mem_data_i,
   output logic                  core_mem_ack_o,
   output link_pkg::rsp_t        core_mem_rsp_o,
   output logic                  mem_req_o,
   output link_pkg::core_req_t   mem_req_data_o,
   input  logic                  mem_ack_i,
   input  link_pkg::rsp_t        mem_rsp_i,

   output logic                  core_reset_o
);

   addr_map_pkg::core_addr_t    dram_base;
   logic                        prof_v;
   addr_map_pkg::region_t       prof_region;
   logic                        oor;
   logic [`BRIDGE_REGIONS-1:0]  prof_map;
   link_pkg::word_t             oor_count;

   bridge_csr i_bridge_csr
   (
      .aclk_i         (aclk_i),
      .reset_i        (reset_i),
      .csr_req_i      (csr_req_i),
      .csr_req_data_i (csr_req_data_i),
      .prof_map_i     (prof_map),
      .oor_count_i    (oor_count),
      .csr_ack_o      (csr_ack_o),
      .csr_rsp_o      (csr_rsp_o),
      .dram_base_o    (dram_base),
      .core_reset_o   (core_reset_o)
   );

   host_addr_xlate i_host_addr_xlate
   (
      .aclk_i          (aclk_i),
      .reset_i         (reset_i),
      .host_req_i      (host_req_i),
      .host_req_data_i (host_req_data_i),
      .core_ack_i      (core_ack_i),
      .core_rsp_i      (core_rsp_i),
      .host_ack_o      (host_ack_o),
      .host_rsp_o      (host_rsp_o),
      .core_req_o      (core_req_o),
      .core_req_data_o (core_req_data_o)
   );

   dram_remap i_dram_remap
   (
      .aclk_i          (aclk_i),
      .reset_i         (reset_i),
      .core_mem_req_i  (core_mem_req_i),
      .core_mem_data_i (core_mem_data_i),
      .dram_base_i     (dram_base),
      .mem_ack_i       (mem_ack_i),
      .mem_rsp_i       (mem_rsp_i),
      .core_mem_ack_o  (core_mem_ack_o),
      .core_mem_rsp_o  (core_mem_rsp_o),
      .mem_req_o       (mem_req_o),
      .mem_req_data_o  (mem_req_data_o),
      .prof_v_o        (prof_v),
      .prof_region_o   (prof_region),
      .oor_o           (oor)
   );

   // profiler state follows the core reset, not the bridge reset
   mem_profiler i_mem_profiler
   (
      .aclk_i        (aclk_i),
      .core_reset_i  (core_reset_o),
      .prof_v_i      (prof_v),
      .prof_region_i (prof_region),
      .oor_i         (oor),
      .prof_map_o    (prof_map),
      .oor_count_o   (oor_count)
   );

endmodule

`default_nettype wire

/* testbench/tb_zynq_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_settings.svh"

module tb_zynq_bridge;

   localparam logic [31:0] lcg_seed   = 32'ha102_783f;
   localparam int          n_host     = 40;
   localparam int          n_dram     = 60;
   // four sweeps over the eight registers and seven register writes
   localparam int          n_csr      = 39;
   localparam int          max_cycles = 64 * (n_host + n_dram + n_csr) + 16;

   logic                       clk;
   logic                       reset;
   logic                       csr_req       = 1'b0;
   link_pkg::csr_req_t         csr_req_data  = '0;
   logic                       host_req      = 1'b0;
   link_pkg::host_req_t        host_req_data = '0;
   logic                       core_ack      = 1'b0;
   link_pkg::rsp_t             core_rsp      = '0;
   logic                       core_mem_req  = 1'b0;
   link_pkg::core_req_t        core_mem_data = '0;
   logic                       mem_ack       = 1'b0;
   link_pkg::rsp_t             mem_rsp       = '0;
   logic                       csr_ack;
   link_pkg::rsp_t             csr_rsp;
   logic                       host_ack;
   link_pkg::rsp_t             host_rsp;
   logic                       core_req;
   link_pkg::core_req_t        core_req_data;
   logic                       core_mem_ack;
   link_pkg::rsp_t             core_mem_rsp;
   logic                       mem_req;
   link_pkg::core_req_t        mem_req_data;
   logic                       core_reset;

   // each process draws from a stream of its own so results do not depend on process order
   logic [31:0]                host_seed = lcg_seed;
   logic [31:0]                dram_seed = lcg_seed ^ 32'h5a5a_0001;
   logic [31:0]                core_seed = lcg_seed ^ 32'h0f0f_0002;
   logic [31:0]                mem_seed  = lcg_seed ^ 32'h3c3c_0003;
   logic [31:0]                csr_seed  = lcg_seed ^ 32'h9696_0004;
   logic [2:0]                 core_wait = 3'd0;
   logic [2:0]                 mem_wait  = 3'd0;
   link_pkg::core_req_t        core_seen;
   link_pkg::core_req_t        mem_seen;

   // reference model of the register block and the profiler
   logic                       model_run   = 1'b0;
   logic                       model_alloc = 1'b0;
   addr_map_pkg::core_addr_t   model_base  = '0;
   logic [`BRIDGE_REGIONS-1:0] model_map   = '0;
   link_pkg::word_t            model_oor   = '0;
   int                         req_errs    = 0;
   int                         rsp_errs    = 0;
   int                         word_errs   = 0;
   int                         cycles      = 0;

   zynq_bridge_top i_zynq_bridge_top
   (
      .aclk_i          (clk),
      .reset_i         (reset),
      .csr_req_i       (csr_req),
      .csr_req_data_i  (csr_req_data),
      .csr_ack_o       (csr_ack),
      .csr_rsp_o       (csr_rsp),
      .host_req_i      (host_req),
      .host_req_data_i (host_req_data),
      .host_ack_o      (host_ack),
      .host_rsp_o      (host_rsp),
      .core_req_o      (core_req),
      .core_req_data_o (core_req_data),
      .core_ack_i      (core_ack),
      .core_rsp_i      (core_rsp),
      .core_mem_req_i  (core_mem_req),
      .core_mem_data_i (core_mem_data),
      .core_mem_ack_o  (core_mem_ack),
      .core_mem_rsp_o  (core_mem_rsp),
      .mem_req_o       (mem_req),
      .mem_req_data_o  (mem_req_data),
      .mem_ack_i       (mem_ack),
      .mem_rsp_i       (mem_rsp),
      .core_reset_o    (core_reset)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // host bit 29 clear selects core DRAM at the top of the core space
   function automatic addr_map_pkg::core_addr_t expect_xlate(input addr_map_pkg::host_addr_t a);
      addr_map_pkg::core_addr_t c;
      c = {4'b0000, a[27:0]};
      if (!a[29])
         c = c | 32'h8000_0000;
      return c;
   endfunction

   function automatic link_pkg::word_t expect_csr(input addr_map_pkg::csr_idx_t idx);
      case (idx)
         `CSR_RUN:   return {31'b0, model_run};
         `CSR_ALLOC: return {31'b0, model_alloc};
         `CSR_BASE:  return model_base;
         `CSR_PROF0: return model_map[31:0];
         `CSR_PROF1: return model_map[63:32];
         `CSR_PROF2: return model_map[95:64];
         `CSR_PROF3: return model_map[127:96];
         `CSR_OOR:   return model_oor;
         default:    return '0;
      endcase
   endfunction

   task automatic check_req(input link_pkg::core_req_t got, input link_pkg::core_req_t exp,
                            input string what);
      if (got !== exp)
      begin
         req_errs = req_errs + 1;
         $display("ERR %0t: %s request addr %08h we %0d data %08h, expected %08h %0d %08h",
                  $time, what, got.addr, got.we, got.data, exp.addr, exp.we, exp.data);
      end
   endtask

   task automatic check_rsp(input link_pkg::rsp_t got, input link_pkg::rsp_t exp,
                            input string what);
      if (got !== exp)
      begin
         rsp_errs = rsp_errs + 1;
         $display("ERR %0t: %s read data %08h, expected %08h", $time, what, got.data, exp.data);
      end
   endtask

   task automatic check_word(input link_pkg::word_t got, input link_pkg::word_t exp,
                             input string what);
      if (got !== exp)
      begin
         word_errs = word_errs + 1;
         $display("ERR %0t: %s is %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic csr_access(input addr_map_pkg::csr_idx_t idx, input logic we,
                             input link_pkg::word_t data, output link_pkg::rsp_t rsp);
      link_pkg::csr_req_t req;
      req.idx  = idx;
      req.we   = we;
      req.data = data;
      @(posedge clk);
      csr_req      <= 1'b1;
      csr_req_data <= req;
      @(posedge clk);
      while (csr_ack !== 1'b1)
         @(posedge clk);
      rsp = csr_rsp;
      csr_req <= 1'b0;
      while (csr_ack !== 1'b0)
         @(posedge clk);
   endtask

   task automatic csr_write(input addr_map_pkg::csr_idx_t idx, input link_pkg::word_t data);
      link_pkg::rsp_t rsp;
      csr_access(idx, 1'b1, data, rsp);
      case (idx)
         `CSR_RUN:   model_run   = data[0];
         `CSR_ALLOC: model_alloc = data[0];
         `CSR_BASE:  model_base  = data;
         default:    ;
      endcase
      // the profiler is held cleared while the core is in reset
      if (!model_run)
      begin
         model_map = '0;
         model_oor = '0;
      end
   endtask

   task automatic check_all_csrs();
      link_pkg::rsp_t rsp;
      for (int i = 0; i < 8; i++)
      begin
         csr_access(i[2:0], 1'b0, 32'h0, rsp);
         check_word(rsp.data, expect_csr(i[2:0]), $sformatf("register %0d", i));
      end
   endtask

   task automatic run_host_batch();
      link_pkg::host_req_t req;
      link_pkg::core_req_t exp;
      for (int i = 0; i < n_host; i++)
      begin
         host_seed = lcg_step(host_seed);
         req.addr  = host_seed[31:2];
         host_seed = lcg_step(host_seed);
         req.we    = host_seed[31];
         host_seed = lcg_step(host_seed);
         req.data  = host_seed;
         exp.addr  = expect_xlate(req.addr);
         exp.we    = req.we;
         exp.data  = req.data;
         @(posedge clk);
         host_req      <= 1'b1;
         host_req_data <= req;
         @(posedge clk);
         while (host_ack !== 1'b1)
            @(posedge clk);
         check_req(core_seen, exp, "host");
         check_rsp(host_rsp, core_rsp, "host");
         host_req <= 1'b0;
         while (host_ack !== 1'b0)
            @(posedge clk);
      end
   endtask

   task automatic run_dram_batch();
      link_pkg::core_req_t      req;
      link_pkg::core_req_t      exp;
      addr_map_pkg::core_addr_t offset;
      logic [1:0]               pick;
      for (int i = 0; i < n_dram; i++)
      begin
         dram_seed = lcg_step(dram_seed);
         pick      = dram_seed[31:30];
         dram_seed = lcg_step(dram_seed);
         // mostly inside the first 128 MiB so the limit is crossed only now and then
         case (pick)
            2'd0, 2'd1: req.addr = 32'h8000_0000 | {5'b0, dram_seed[31:5]};
            2'd2:       req.addr = {2'b10, dram_seed[31:2]};
            default:    req.addr = dram_seed;
         endcase
         dram_seed = lcg_step(dram_seed);
         req.we    = dram_seed[30];
         dram_seed = lcg_step(dram_seed);
         req.data  = dram_seed;
         offset    = req.addr ^ 32'h8000_0000;
         exp.addr  = offset + model_base;
         exp.we    = req.we;
         exp.data  = req.data;
         if (model_run)
         begin
            model_map[req.addr[29:23]] = 1'b1;
            if (offset >= 32'd125829120)
               model_oor = model_oor + 32'd1;
         end
         @(posedge clk);
         core_mem_req  <= 1'b1;
         core_mem_data <= req;
         @(posedge clk);
         while (core_mem_ack !== 1'b1)
            @(posedge clk);
         check_req(mem_seen, exp, "dram");
         check_rsp(core_mem_rsp, mem_rsp, "dram");
         core_mem_req <= 1'b0;
         while (core_mem_ack !== 1'b0)
            @(posedge clk);
      end
   endtask

   // the core side responder answers after a random delay with random read data
   always @(posedge clk)
   begin
      if (reset)
         core_ack <= 1'b0;
      else if (core_ack)
      begin
         if (!core_req)
            core_ack <= 1'b0;
      end
      else if (core_req)
      begin
         if (core_wait == 3'd0)
         begin
            core_seed = lcg_step(core_seed);
            core_ack      <= 1'b1;
            core_rsp.data <= core_seed;
            core_seen     <= core_req_data;
            core_seed = lcg_step(core_seed);
            core_wait     <= core_seed[31:29];
         end
         else
            core_wait <= core_wait - 3'd1;
      end
   end

   // memory side responder
   always @(posedge clk)
   begin
      if (reset)
         mem_ack <= 1'b0;
      else if (mem_ack)
      begin
         if (!mem_req)
            mem_ack <= 1'b0;
      end
      else if (mem_req)
      begin
         if (mem_wait == 3'd0)
         begin
            mem_seed = lcg_step(mem_seed);
            mem_ack      <= 1'b1;
            mem_rsp.data <= mem_seed;
            mem_seen     <= mem_req_data;
            mem_seed = lcg_step(mem_seed);
            mem_wait     <= mem_seed[31:29];
         end
         else
            mem_wait <= mem_wait - 3'd1;
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("Timeout: the run did not finish within %0d cycles", max_cycles);
         $display("Verification failed");
         $finish;
      end
   end

   initial
   begin
      reset = 1'b1;
      repeat (8) @(posedge clk);
      check_word({31'b0, core_reset}, 32'd1, "core reset during reset");
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      @(posedge clk);
      check_word({31'b0, core_reset}, 32'd1, "core reset with run clear");
      check_all_csrs();
      csr_seed = lcg_step(csr_seed);
      csr_write(`CSR_ALLOC, csr_seed | 32'd1);
      csr_seed = lcg_step(csr_seed);
      csr_write(`CSR_BASE, csr_seed);
      csr_write(`CSR_RUN, 32'd1);
      check_word({31'b0, core_reset}, 32'd0, "core reset with run set");
      // status words ignore writes
      csr_write(`CSR_PROF0, 32'hffff_ffff);
      csr_write(`CSR_OOR, 32'h0000_1234);
      check_all_csrs();
      fork
         run_host_batch();
         run_dram_batch();
      join
      check_all_csrs();
      csr_write(`CSR_RUN, 32'd0);
      check_word({31'b0, core_reset}, 32'd1, "core reset after run cleared");
      csr_write(`CSR_RUN, 32'd1);
      check_word({31'b0, core_reset}, 32'd0, "core reset after run set again");
      check_all_csrs();
      $display("errors: request %0d, read data %0d, register %0d",
               req_errs, rsp_errs, word_errs);
      if (req_errs + rsp_errs + word_errs == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/addr_map_pkg.sv
hdl/link_pkg.sv
hdl/bridge_csr.sv
hdl/host_addr_xlate.sv
hdl/dram_remap.sv
hdl/mem_profiler.sv
hdl/zynq_bridge_top.sv
testbench/tb_zynq_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_zynq_bridge \
   -f verilog.f \
   -o tb_zynq_bridge
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_zynq_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Verification passed$" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
